//--- common/ddr_cmd_pkg.sv
`default_nettype none

package ddr_cmd_pkg;

  // Pin encoding is {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOP       = 3'b111,
    ACTIVE    = 3'b011,
    READ      = 3'b101,
    WRITE     = 3'b100,
    PRECHARGE = 3'b010,
    REFRESH   = 3'b001,
    LOAD_MODE = 3'b000
  } sdram_cmd_t;

  typedef struct packed {
    sdram_cmd_t  cmd;
    logic [12:0] addr;
    logic [1:0]  bank;
  } cmd_pins_t;

  // Timing in clk_n cycles
  localparam int T_RCD = 2;
  localparam int T_RP = 2;
  localparam int T_RFC = 7;
  localparam int T_WR = 2;
  localparam int CAS_LAT = 2;

  // Sequential burst of 2, CL 2
  localparam logic [12:0] MODE_WORD = 13'h021;

  localparam logic [12:0] A10_MASK = 13'h0400; // All banks / auto-precharge

endpackage

`default_nettype wire

//--- common/ddr_req_pkg.sv
`default_nettype none

package ddr_req_pkg;

  typedef struct packed {
    logic [23:0] addr;     // Word address
    logic        we;
    logic [3:0]  we_array; // Byte enables, 1 writes the byte
    logic [31:0] data;
  } user_req_t;

  function automatic logic [8:0] addr_col(input logic [23:0] a);
    return a[8:0];
  endfunction

  function automatic logic [1:0] addr_bank(input logic [23:0] a);
    return a[10:9];
  endfunction

  function automatic logic [12:0] addr_row(input logic [23:0] a);
    return a[23:11];
  endfunction

endpackage

`default_nettype wire

//--- source/power_up_init.sv
`default_nettype none
`timescale 1ns/1ns

module power_up_init #(
  parameter int INIT_CYCLES = 200
) (
  input  wire                     clk_n,
  input  wire                     reset,
  input  wire ddr_cmd_pkg::cmd_pins_t seq_pins,
  output logic                    cke,
  output ddr_cmd_pkg::sdram_cmd_t cmd,
  output logic [12:0]             addr,
  output logic [1:0]              bank,
  output logic                    init_done
);
  import ddr_cmd_pkg::*;

  typedef enum logic [2:0] {
    ST_WAIT,
    ST_PRE,
    ST_REF1,
    ST_REF2,
    ST_MODE,
    ST_MRD,
    ST_RUN
  } init_state_t;

  init_state_t state;
  logic [15:0] cnt;

  always_ff @(posedge clk_n) begin
    if (reset) begin
      state <= ST_WAIT;
      cnt <= 16'(INIT_CYCLES - 1);
      cke <= 1'b0;
      cmd <= NOP;
      addr <= '0;
      bank <= '0;
      init_done <= 1'b0;
    end else begin
      cmd <= NOP;
      case (state)
        ST_WAIT: begin
          if (cnt == 0) begin
            cke <= 1'b1;
            state <= ST_PRE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_PRE: begin
          cmd <= PRECHARGE;
          addr <= A10_MASK; // Precharge all banks
          cnt <= 16'(T_RP - 1);
          state <= ST_REF1;
        end
        ST_REF1: begin
          if (cnt == 0) begin
            cmd <= REFRESH;
            cnt <= 16'(T_RFC - 1);
            state <= ST_REF2;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_REF2: begin
          if (cnt == 0) begin
            cmd <= REFRESH;
            cnt <= 16'(T_RFC - 1);
            state <= ST_MODE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_MODE: begin
          if (cnt == 0) begin
            cmd <= LOAD_MODE;
            addr <= MODE_WORD;
            bank <= 2'b00;
            cnt <= 16'(T_RP - 1); // tMRD
            state <= ST_MRD;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_MRD: begin
          if (cnt == 0) begin
            init_done <= 1'b1;
            state <= ST_RUN;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_RUN: begin
          cmd <= seq_pins.cmd; // Sequencer owns the bus from here on
          addr <= seq_pins.addr;
          bank <= seq_pins.bank;
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/port_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module port_arbiter (
  input  wire                       clk_n,
  input  wire                       reset,
  input  wire                       init_done,
  input  wire                       refresh_strobe,
  input  wire                       refresh_done,
  input  wire                       rand_req,
  input  wire ddr_req_pkg::user_req_t rand_req_bus,
  input  wire                       bulk_req,
  input  wire ddr_req_pkg::user_req_t bulk_req_bus,
  input  wire                       accept,
  output logic                      refresh_req,
  output logic                      grant_valid,
  output logic                      grant_port,
  output ddr_req_pkg::user_req_t    grant_req,
  output logic                      rand_req_ack,
  output logic                      bulk_req_ack
);

  logic refresh_pending;
  logic grant_q;
  logic last_port; // 1 when bulk was served last
  logic pick_bulk;
  logic can_pick;

  assign refresh_req = refresh_pending && init_done;
  assign grant_valid = grant_q && !refresh_pending; // Refresh goes first

  // Both waiting means the port not served last wins
  assign pick_bulk = bulk_req && (!rand_req || !last_port);

  // Requester still holds its level in the ack cycle
  assign can_pick = init_done && !grant_q && !rand_req_ack && !bulk_req_ack &&
                    (rand_req || bulk_req);

  always_ff @(posedge clk_n) begin
    if (reset) begin
      refresh_pending <= 1'b0;
      grant_q <= 1'b0;
      grant_port <= 1'b0;
      last_port <= 1'b1;
      rand_req_ack <= 1'b0;
      bulk_req_ack <= 1'b0;
    end else begin
      rand_req_ack <= accept && !grant_port;
      bulk_req_ack <= accept && grant_port;

      if (refresh_strobe) begin
        refresh_pending <= 1'b1;
      end else if (refresh_done) begin
        refresh_pending <= 1'b0;
      end

      if (accept) begin
        grant_q <= 1'b0;
        last_port <= grant_port;
      end else if (can_pick) begin
        grant_q <= 1'b1;
        grant_port <= pick_bulk;
      end
    end
  end

  always_ff @(posedge clk_n) begin
    if (can_pick) begin
      grant_req <= pick_bulk ? bulk_req_bus : rand_req_bus;
    end
  end

endmodule

`default_nettype wire

//--- sequencer/bank_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

module bank_sequencer (
  input  wire                       clk_n,
  input  wire                       reset,
  input  wire                       refresh_req,
  input  wire                       grant_valid,
  input  wire ddr_req_pkg::user_req_t grant_req,
  output logic                      accept,
  output logic                      refresh_done,
  output ddr_cmd_pkg::cmd_pins_t    seq_pins,
  output logic                      wr_start,
  output logic                      rd_start,
  output logic [31:0]               wr_word,
  output logic [3:0]                wr_mask
);
  import ddr_cmd_pkg::*;
  import ddr_req_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RCD,
    S_WAIT
  } seq_state_t;

  seq_state_t state;
  logic [3:0] cnt;
  logic [1:0] bank_q;
  logic [8:0] col_q;
  logic       we_q;

  assign accept = (state == S_IDLE) && grant_valid && !refresh_req;
  assign refresh_done = (state == S_IDLE) && refresh_req;

  always_ff @(posedge clk_n) begin
    if (accept) begin
      bank_q <= addr_bank(grant_req.addr);
      col_q <= addr_col(grant_req.addr);
      we_q <= grant_req.we;
      wr_word <= grant_req.data;
      wr_mask <= ~grant_req.we_array; // DM is active high masking
    end
  end

  always_ff @(posedge clk_n) begin
    if (reset) begin
      state <= S_IDLE;
      cnt <= '0;
      seq_pins <= '{cmd: NOP, addr: '0, bank: '0};
      wr_start <= 1'b0;
      rd_start <= 1'b0;
    end else begin
      seq_pins.cmd <= NOP;
      wr_start <= 1'b0;
      rd_start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (refresh_done) begin
            seq_pins.cmd <= REFRESH;
            cnt <= 4'(T_RFC - 2);
            state <= S_WAIT;
          end else if (accept) begin
            seq_pins <= '{cmd: ACTIVE,
                          addr: addr_row(grant_req.addr),
                          bank: addr_bank(grant_req.addr)};
            cnt <= 4'(T_RCD - 1);
            state <= S_RCD;
          end
        end
        S_RCD: begin
          if (cnt == 0) begin
            // Column pins are word column times two, A10 for auto-precharge
            seq_pins.addr <= A10_MASK | {3'b000, col_q, 1'b0};
            seq_pins.bank <= bank_q;
            if (we_q) begin
              seq_pins.cmd <= WRITE;
              wr_start <= 1'b1;
              cnt <= 4'(T_WR + T_RP - 1);
            end else begin
              seq_pins.cmd <= READ;
              rd_start <= 1'b1;
              cnt <= 4'(CAS_LAT + T_RP); // Wait out the read data too
            end
            state <= S_WAIT;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        S_WAIT: begin
          if (cnt == 0) begin
            state <= S_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/data_path.sv
`default_nettype none
`timescale 1ns/1ns

module data_path (
  input  wire         clk_n,
  input  wire         reset,
  input  wire         wr_start,
  input  wire  [31:0] wr_word,
  input  wire  [3:0]  wr_mask,
  input  wire         rd_start,
  input  wire  [15:0] dq_in,
  output logic [15:0] dq_out,
  output logic        dq_oe,
  output logic [1:0]  dm,
  output logic [31:0] rd_data,
  output logic        rd_valid
);
  import ddr_cmd_pkg::*;

  logic               wr_hi;   // Second write beat pending
  logic [CAS_LAT-1:0] rd_shift;
  logic               cap_lo;
  logic               cap_hi;
  logic [15:0]        rd_lo;

  always_ff @(posedge clk_n) begin
    if (reset) begin
      dq_oe <= 1'b0;
      wr_hi <= 1'b0;
      rd_shift <= '0;
      cap_lo <= 1'b0;
      cap_hi <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      dq_oe <= wr_start || wr_hi;
      wr_hi <= wr_start;
      rd_shift <= {rd_shift[CAS_LAT-2:0], rd_start};
      cap_lo <= rd_shift[CAS_LAT-1]; // First beat on dq_in next cycle
      cap_hi <= cap_lo;
      rd_valid <= cap_hi;
    end
  end

  // Low half goes out first
  always_ff @(posedge clk_n) begin
    if (wr_start) begin
      dq_out <= wr_word[15:0];
      dm <= wr_mask[1:0];
    end else if (wr_hi) begin
      dq_out <= wr_word[31:16];
      dm <= wr_mask[3:2];
    end else begin
      dm <= 2'b00;
    end
  end

  always_ff @(posedge clk_n) begin
    if (cap_lo) begin
      rd_lo <= dq_in;
    end
    if (cap_hi) begin
      rd_data <= {dq_in, rd_lo};
    end
  end

endmodule

`default_nettype wire

//--- source/ddr_controller.sv
`default_nettype none
`timescale 1ns/1ns

module ddr_controller #(
  parameter int INIT_CYCLES = 200
) (
  input  wire                       clk_n,
  input  wire                       reset,
  input  wire                       refresh_strobe,
  input  wire                       rand_req,
  input  wire ddr_req_pkg::user_req_t rand_req_bus,
  output logic                      rand_req_ack,
  input  wire                       bulk_req,
  input  wire ddr_req_pkg::user_req_t bulk_req_bus,
  output logic                      bulk_req_ack,
  output logic [31:0]               rd_data,
  output logic                      rd_valid,
  output logic                      cke,
  output logic                      cs_n,
  output ddr_cmd_pkg::sdram_cmd_t   cmd,
  output logic [12:0]               addr,
  output logic [1:0]                bank,
  output logic [15:0]               dq_out,
  output logic                      dq_oe,
  output logic [1:0]                dm,
  input  wire  [15:0]               dq_in
);
  import ddr_cmd_pkg::*;
  import ddr_req_pkg::*;

  logic        init_done;
  logic        refresh_req;
  logic        refresh_done;
  logic        grant_valid;
  user_req_t   grant_req;
  logic        accept;
  cmd_pins_t   seq_pins;
  logic        wr_start;
  logic        rd_start;
  logic [31:0] wr_word;
  logic [3:0]  wr_mask;

  assign cs_n = 1'b0; // Single rank, always selected

  power_up_init #(
    .INIT_CYCLES(INIT_CYCLES)
  ) u_init (
    .clk_n(clk_n),
    .reset(reset),
    .seq_pins(seq_pins),
    .cke(cke),
    .cmd(cmd),
    .addr(addr),
    .bank(bank),
    .init_done(init_done)
  );

  port_arbiter u_arb (
    .clk_n(clk_n),
    .reset(reset),
    .init_done(init_done),
    .refresh_strobe(refresh_strobe),
    .refresh_done(refresh_done),
    .rand_req(rand_req),
    .rand_req_bus(rand_req_bus),
    .bulk_req(bulk_req),
    .bulk_req_bus(bulk_req_bus),
    .accept(accept),
    .refresh_req(refresh_req),
    .grant_valid(grant_valid),
    .grant_port(),
    .grant_req(grant_req),
    .rand_req_ack(rand_req_ack),
    .bulk_req_ack(bulk_req_ack)
  );

  bank_sequencer u_seq (
    .clk_n(clk_n),
    .reset(reset),
    .refresh_req(refresh_req),
    .grant_valid(grant_valid),
    .grant_req(grant_req),
    .accept(accept),
    .refresh_done(refresh_done),
    .seq_pins(seq_pins),
    .wr_start(wr_start),
    .rd_start(rd_start),
    .wr_word(wr_word),
    .wr_mask(wr_mask)
  );

  data_path u_dp (
    .clk_n(clk_n),
    .reset(reset),
    .wr_start(wr_start),
    .wr_word(wr_word),
    .wr_mask(wr_mask),
    .rd_start(rd_start),
    .dq_in(dq_in),
    .dq_out(dq_out),
    .dq_oe(dq_oe),
    .dm(dm),
    .rd_data(rd_data),
    .rd_valid(rd_valid)
  );

endmodule

`default_nettype wire

//--- tb/ddr_controller_chk.sv
`default_nettype none
`timescale 1ns/1ns

module ddr_controller_chk (
  input wire                          clk_n,
  input wire                          reset,
  input wire                          init_done,
  input wire                          rand_req_ack,
  input wire                          bulk_req_ack,
  input wire ddr_cmd_pkg::sdram_cmd_t cmd,
  input wire                          dq_oe
);
  import ddr_cmd_pkg::*;

  // One port served per ack
  acks_exclusive: assert property (@(posedge clk_n) disable iff (reset)
    !(rand_req_ack && bulk_req_ack))
    else $error("both port acks high in the same cycle");

  // Only the init sequence may touch the bus before init_done
  init_cmds_only: assert property (@(posedge clk_n) disable iff (reset)
    !init_done |-> (cmd == NOP || cmd == PRECHARGE || cmd == REFRESH || cmd == LOAD_MODE))
    else $error("user command issued before init_done");

  // T_RCD of 2 means no column command right after ACTIVE
  rcd_gap: assert property (@(posedge clk_n) disable iff (reset)
    cmd == ACTIVE |=> (cmd != READ && cmd != WRITE))
    else $error("READ or WRITE issued too soon after ACTIVE");

  dq_oe_window: assert property (@(posedge clk_n) disable iff (reset)
    dq_oe |-> (cmd == WRITE || $past(cmd) == WRITE))
    else $error("dq_oe high outside the two write beat cycles");

endmodule

bind ddr_controller ddr_controller_chk u_chk (
  .clk_n(clk_n),
  .reset(reset),
  .init_done(init_done),
  .rand_req_ack(rand_req_ack),
  .bulk_req_ack(bulk_req_ack),
  .cmd(cmd),
  .dq_oe(dq_oe)
);

`default_nettype wire

//--- tb/tb_ddr_controller.sv
`default_nettype none
`timescale 1ns/1ns

module tb_ddr_controller;
  import ddr_cmd_pkg::*;
  import ddr_req_pkg::*;

  localparam int LIMIT = 300;

  logic        clk_n;
  logic        reset;
  logic        refresh_strobe;
  logic        rand_req;
  user_req_t   rand_req_bus;
  logic        bulk_req;
  user_req_t   bulk_req_bus;
  logic [15:0] dq_in = '0;
  logic        rand_req_ack;
  logic        bulk_req_ack;
  logic [31:0] rd_data;
  logic        rd_valid;
  logic        cke;
  logic        cs_n;
  sdram_cmd_t  cmd;
  logic [12:0] addr;
  logic [1:0]  bank;
  logic [15:0] dq_out;
  logic        dq_oe;
  logic [1:0]  dm;

  // Memory model state
  logic [15:0] mem [logic [24:0]];
  logic [12:0] open_row [4];
  logic [24:0] wr_key = '0;
  logic        wr_second = 1'b0;
  logic [24:0] rd_key = '0;
  logic        rd_busy = 1'b0;
  int          rd_age = 0;

  logic [31:0] lfsr = 32'hdf18;
  string       cur_test;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          rd_count = 0;

  ddr_controller #(
    .INIT_CYCLES(20)
  ) u_dut (
    .clk_n(clk_n), .reset(reset), .refresh_strobe(refresh_strobe),
    .rand_req(rand_req), .rand_req_bus(rand_req_bus), .rand_req_ack(rand_req_ack),
    .bulk_req(bulk_req), .bulk_req_bus(bulk_req_bus), .bulk_req_ack(bulk_req_ack),
    .rd_data(rd_data), .rd_valid(rd_valid), .cke(cke), .cs_n(cs_n), .cmd(cmd),
    .addr(addr), .bank(bank), .dq_out(dq_out), .dq_oe(dq_oe), .dm(dm), .dq_in(dq_in)
  );

  initial begin
    clk_n = 1'b0;
    forever #4 clk_n = ~clk_n;
  end

  // Unwritten locations read back a word made from the whole key
  function automatic logic [15:0] fill_word(input logic [24:0] key);
    return key[15:0] ^ {key[24:16], 7'h5a};
  endfunction

  function automatic logic [15:0] load_beat(input logic [24:0] key);
    if (mem.exists(key)) return mem[key];
    return fill_word(key);
  endfunction

  task automatic store_beat(input logic [24:0] key, input logic [15:0] d, input logic [1:0] m);
    logic [15:0] old;
    old = load_beat(key);
    mem[key] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
  endtask

  always @(posedge clk_n) begin
    #1;
    if (wr_second) begin
      check_val("dq_oe on write beat", 32'd1, 32'(dq_oe));
      store_beat(wr_key + 25'd1, dq_out, dm);
      wr_second = 1'b0;
    end
    if (cmd == ACTIVE) open_row[bank] = addr;
    if (cmd == WRITE) begin
      check_val("dq_oe on write beat", 32'd1, 32'(dq_oe));
      wr_key = {bank, open_row[bank], addr[9:0]};
      store_beat(wr_key, dq_out, dm);
      wr_second = 1'b1;
    end
    if (rd_busy) begin
      rd_age = rd_age + 1;
      if (rd_age == CAS_LAT) dq_in = load_beat(rd_key);
      if (rd_age == CAS_LAT + 1) begin
        dq_in = load_beat(rd_key + 25'd1);
        rd_busy = 1'b0;
      end
    end
    if (cmd == READ) begin
      rd_key = {bank, open_row[bank], addr[9:0]};
      rd_age = 0;
      rd_busy = 1'b1;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic user_req_t make_req(input logic [23:0] a, input logic we,
                                         input logic [3:0] be, input logic [31:0] d);
    return '{addr: a, we: we, we_array: be, data: d};
  endfunction

  task automatic step();
    @(posedge clk_n);
    #1;
    if (rd_valid) rd_count++;
  endtask

  task automatic abort_run(input string why);
    $display("%s in test %s", why, cur_test);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors != 0) tests_failed++;
    $display("test %s: %s", cur_test, (test_errors == 0) ? "ok" : "FAILED");
  endtask

  // One request through a port, with the address mapping checked on the pins
  task automatic run_access(input logic use_bulk, input user_req_t req,
                            output logic [31:0] data);
    int t;
    if (use_bulk) begin
      bulk_req_bus = req;
      bulk_req = 1'b1;
    end else begin
      rand_req_bus = req;
      rand_req = 1'b1;
    end
    t = 0;
    while (!(use_bulk ? bulk_req_ack : rand_req_ack)) begin
      step();
      t++;
      if (t > LIMIT) abort_run("No ack for a held request");
    end
    rand_req = 1'b0;
    bulk_req = 1'b0;
    t = 0;
    while (cmd != ACTIVE) begin
      step();
      t++;
      if (t > LIMIT) abort_run("No ACTIVE after ack");
    end
    check_val("active bank", 32'(req.addr[10:9]), 32'(bank));
    check_val("active row", 32'(req.addr[23:11]), 32'(addr));
    t = 0;
    while (cmd != READ && cmd != WRITE) begin
      step();
      t++;
      if (t > LIMIT) abort_run("No READ or WRITE after ACTIVE");
    end
    check_val("column pins", 32'({req.addr[8:0], 1'b0}), 32'(addr[9:0]));
    check_val("column bank", 32'(req.addr[10:9]), 32'(bank));
    data = '0;
    if (!req.we) begin
      t = 0;
      while (!rd_valid) begin
        step();
        t++;
        if (t > LIMIT) abort_run("No rd_valid after READ");
      end
      data = rd_data;
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] got;
    sdram_cmd_t  seen_cmd [8];
    logic [12:0] seen_addr [8];
    int          n;
    int          t;
    int          cke_low;
    int          last;
    int          base;
    logic        saw_ref;

    reset = 1'b1;
    refresh_strobe = 1'b0;
    rand_req = 1'b0;
    bulk_req = 1'b0;
    rand_req_bus = '0;
    bulk_req_bus = '0;
    repeat (10) @(posedge clk_n);
    #1;
    reset = 1'b0;

    start_test("init");
    take_bits(24, a);
    take_bits(32, d0);
    rand_req_bus = make_req(a[23:0], 1'b1, 4'hf, d0);
    rand_req = 1'b1; // Held through init, ack must wait
    check_val("cs_n", 32'd0, 32'(cs_n));
    cke_low = 0;
    while (cke == 1'b0) begin
      cke_low++;
      step();
      if (cke_low > LIMIT) abort_run("CKE never rose");
    end
    check_val("cke low cycles", 32'd20, 32'(cke_low));
    n = 0;
    t = 0;
    while (!u_dut.init_done) begin
      if (cmd != NOP && n < 8) begin
        seen_cmd[n] = cmd;
        seen_addr[n] = addr;
        n++;
      end
      if (rand_req_ack || bulk_req_ack) begin
        $display("Ack given before initialization ended");
        errors++;
        test_errors++;
      end
      step();
      t++;
      if (t > LIMIT) abort_run("init_done never rose");
    end
    check_val("init command count", 32'd4, 32'(n));
    if (n == 4) begin
      check_val("cmd 0", 32'(PRECHARGE), 32'(seen_cmd[0]));
      check_val("precharge A10", 32'd1, 32'(seen_addr[0][10]));
      check_val("cmd 1", 32'(REFRESH), 32'(seen_cmd[1]));
      check_val("cmd 2", 32'(REFRESH), 32'(seen_cmd[2]));
      check_val("cmd 3", 32'(LOAD_MODE), 32'(seen_cmd[3]));
      // CL 2, sequential, burst length 2
      check_val("mode word", 32'({3'b010, 1'b0, 3'b001}), 32'(seen_addr[3]));
    end
    run_access(1'b0, make_req(a[23:0], 1'b1, 4'hf, d0), got);
    end_test();

    start_test("rand_round_trip");
    run_access(1'b0, make_req(a[23:0], 1'b0, 4'h0, 32'h0), got);
    check_val("read data", d0, got);
    end_test();

    start_test("byte_masks");
    take_bits(24, a);
    take_bits(32, d0);
    take_bits(32, d1);
    run_access(1'b1, make_req(a[23:0], 1'b1, 4'hf, d0), got);
    run_access(1'b1, make_req(a[23:0], 1'b1, 4'b0101, d1), got);
    run_access(1'b1, make_req(a[23:0], 1'b0, 4'h0, 32'h0), got);
    check_val("masked word", (d1 & 32'h00ff00ff) | (d0 & 32'hff00ff00), got);
    end_test();

    start_test("contention");
    take_bits(24, a);
    rand_req_bus = make_req(a[23:0], 1'b0, 4'h0, 32'h0);
    take_bits(24, a);
    bulk_req_bus = make_req(a[23:0], 1'b0, 4'h0, 32'h0);
    base = rd_count;
    rand_req = 1'b1;
    bulk_req = 1'b1;
    last = -1;
    for (int k = 0; k < 6; k++) begin
      t = 0;
      step();
      while (!rand_req_ack && !bulk_req_ack) begin
        step();
        t++;
        if (t > LIMIT) abort_run("No ack under contention");
      end
      if (last >= 0) check_val("ack port", 32'(1 - last), 32'(bulk_req_ack));
      last = bulk_req_ack ? 1 : 0;
    end
    rand_req = 1'b0;
    bulk_req = 1'b0;
    t = 0;
    while (rd_count - base < 6) begin
      step();
      t++;
      if (t > LIMIT) abort_run("Contention reads did not all return");
    end
    end_test();

    start_test("refresh_priority");
    take_bits(24, a);
    take_bits(32, d0);
    rand_req_bus = make_req(a[23:0], 1'b1, 4'hf, d0);
    rand_req = 1'b1;
    refresh_strobe = 1'b1;
    step();
    refresh_strobe = 1'b0;
    saw_ref = 1'b0;
    t = 0;
    while (cmd != ACTIVE) begin
      if (cmd == REFRESH) saw_ref = 1'b1;
      if (rand_req_ack) rand_req = 1'b0;
      step();
      t++;
      if (t > LIMIT) abort_run("No ACTIVE after refresh strobe");
    end
    rand_req = 1'b0;
    check_val("refresh before active", 32'd1, 32'(saw_ref));
    end_test();

    start_test("address_mapping");
    for (int k = 0; k < 4; k++) begin
      take_bits(24, a);
      take_bits(32, d0);
      run_access(1'b0, make_req(a[23:0], 1'b1, 4'hf, d0), got);
      run_access(1'b0, make_req(a[23:0], 1'b0, 4'h0, 32'h0), got);
      check_val("read data", d0, got);
    end
    end_test();

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
common/ddr_cmd_pkg.sv
common/ddr_req_pkg.sv
source/power_up_init.sv
source/port_arbiter.sv
sequencer/bank_sequencer.sv
source/data_path.sv
source/ddr_controller.sv
tb/ddr_controller_chk.sv
tb/tb_ddr_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ddr_controller \
  -f files.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out="$(./obj_dir/tb_sim 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
